/* verilog/sm83_pkg.sv */
package sm83_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus types.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [7:0]  word_t;
	typedef logic [15:0] adr_t;

	typedef struct packed {
		logic  rd;
		logic  wr;
		adr_t  adr;
		word_t wdata;
	} bus_req_t;

	typedef enum logic [1:0] {
		alu_add,
		alu_sub,
		alu_and
	} alu_op_t;

	typedef struct packed {
		logic z;
		logic n;
		logic h;
		logic c;
	} flags_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Opcodes of the subset.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam word_t op_nop        = 8'h00;
	localparam word_t op_ld_rr_base = 8'h01; // Register pair in bits 5:4.
	localparam word_t op_ld_a_n     = 8'h3E;
	localparam word_t op_ld_hl_a    = 8'h77;
	localparam word_t op_ld_a_hl    = 8'h7E;
	localparam word_t op_inc_hl     = 8'h23;
	localparam word_t op_add_n      = 8'hC6;
	localparam word_t op_sub_n      = 8'hD6;
	localparam word_t op_and_n      = 8'hE6;
	localparam word_t op_jp         = 8'hC3;
	localparam word_t op_halt       = 8'h76;

	localparam adr_t dma_reg_adr  = 16'h03FF; // Store here starts a copy.
	localparam adr_t dma_dst_base = 16'h0300;

endpackage

/* verilog/sm83_alu.sv */
module sm83_alu (
	input  sm83_pkg::word_t   a,
	input  sm83_pkg::word_t   b,
	input  sm83_pkg::alu_op_t op,
	output sm83_pkg::word_t   result,
	output sm83_pkg::flags_t  flags
);

	logic [8:0] sum;
	logic [4:0] half;

	always_comb begin
		sum   = 9'd0;
		half  = 5'd0;
		flags = '0;

		case (op)
			sm83_pkg::alu_sub: begin
				// Bit 8 and bit 4 come out as borrows.
				sum     = {1'b0, a} - {1'b0, b};
				half    = {1'b0, a[3:0]} - {1'b0, b[3:0]};
				flags.n = 1'b1;
				flags.h = half[4];
				flags.c = sum[8];
			end
			sm83_pkg::alu_and: begin
				sum     = {1'b0, a & b};
				flags.h = 1'b1; // Always set by AND.
			end
			default: begin
				sum     = {1'b0, a} + {1'b0, b};
				half    = {1'b0, a[3:0]} + {1'b0, b[3:0]};
				flags.h = half[4];
				flags.c = sum[8];
			end
		endcase

		result  = sum[7:0];
		flags.z = (sum[7:0] == 8'h00);
	end

endmodule

/* verilog/sm83_core.sv */
module sm83_core (
	input  logic               clk,
	input  logic               reset,
	input  logic               ncyc,
	output sm83_pkg::bus_req_t req,
	input  sm83_pkg::word_t    din,
	output logic               halted
);

	typedef enum logic [2:0] {
		fetch,
		fetch_wait,
		imm_lo,
		imm_hi,
		mem_access,
		mem_wait,
		exec,
		halt
	} state_t;

	localparam int hl_idx = 2; // BC, DE, HL, SP order as in the opcode.

	state_t            state;
	sm83_pkg::adr_t    pc;
	sm83_pkg::adr_t    rr [4];
	sm83_pkg::word_t   a;
	sm83_pkg::flags_t  f;
	sm83_pkg::word_t   ir;
	sm83_pkg::word_t   lo;
	logic              rd_pend;
	sm83_pkg::alu_op_t alu_op;
	sm83_pkg::word_t   alu_res;
	sm83_pkg::flags_t  alu_flags;

	function automatic logic is_ld_rr(input sm83_pkg::word_t op);
		return (op & 8'hCF) == sm83_pkg::op_ld_rr_base;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ALU, immediate operand on b.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign alu_op = (ir == sm83_pkg::op_sub_n) ? sm83_pkg::alu_sub :
	                (ir == sm83_pkg::op_and_n) ? sm83_pkg::alu_and : sm83_pkg::alu_add;

	sm83_alu u_alu (
		.a      (a),
		.b      (din),
		.op     (alu_op),
		.result (alu_res),
		.flags  (alu_flags)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus request.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		req       = '0;
		req.adr   = pc;
		req.wdata = a;
		case (state)
			fetch, imm_lo: req.rd = 1'b1;
			imm_hi:        req.rd = !rd_pend; // Low byte arrives first.
			mem_access: begin
				req.adr = rr[hl_idx];
				req.rd  = (ir == sm83_pkg::op_ld_a_hl);
				req.wr  = (ir == sm83_pkg::op_ld_hl_a);
			end
			default: ;
		endcase
	end

	assign halted = (state == halt);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sequencer.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= fetch;
			pc      <= '0;
			a       <= '0;
			f       <= '0;
			rd_pend <= 1'b0;
			for (int i = 0; i < 4; i++)
				rr[i] <= '0;
		end else begin
			rd_pend <= ncyc;
			case (state)
				fetch: if (ncyc) begin
					pc    <= pc + 16'd1;
					state <= fetch_wait;
				end
				fetch_wait: begin
					case (din)
						sm83_pkg::op_halt: state <= halt;
						sm83_pkg::op_inc_hl: begin
							rr[hl_idx] <= rr[hl_idx] + 16'd1;
							state      <= fetch;
						end
						sm83_pkg::op_ld_hl_a, sm83_pkg::op_ld_a_hl: state <= mem_access;
						sm83_pkg::op_ld_a_n, sm83_pkg::op_add_n, sm83_pkg::op_sub_n,
						sm83_pkg::op_and_n, sm83_pkg::op_jp: state <= imm_lo;
						default: state <= is_ld_rr(din) ? imm_lo : fetch; // Unknown as NOP.
					endcase
				end
				imm_lo: if (ncyc) begin
					pc    <= pc + 16'd1;
					state <= (is_ld_rr(ir) || ir == sm83_pkg::op_jp) ? imm_hi : exec;
				end
				imm_hi: if (ncyc) begin
					pc    <= pc + 16'd1;
					state <= exec;
				end
				mem_access: if (ncyc)
					state <= mem_wait;
				mem_wait: begin
					if (ir == sm83_pkg::op_ld_a_hl)
						a <= din;
					state <= fetch;
				end
				exec: begin
					// Last immediate byte is on din.
					if (is_ld_rr(ir))
						rr[ir[5:4]] <= {din, lo};
					else if (ir == sm83_pkg::op_jp)
						pc <= {din, lo};
					else if (ir == sm83_pkg::op_ld_a_n)
						a <= din;
					else begin
						a <= alu_res;
						f <= alu_flags;
					end
					state <= fetch;
				end
				default: state <= halt; // Stays until reset.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == fetch_wait)
			ir <= din;
		if (state == imm_hi && rd_pend)
			lo <= din;
	end

endmodule

/* verilog/dma_engine.sv */
module dma_engine #(
	parameter int ram_adr_bits = 10,
	parameter int dma_len      = 16
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               start,
	input  sm83_pkg::word_t    start_val,
	input  logic               grant,
	input  sm83_pkg::word_t    rdata,
	output sm83_pkg::bus_req_t req,
	output logic               busy
);

	localparam int cnt_bits = $clog2(dma_len + 1);

	typedef enum logic [1:0] {
		ph_read,
		ph_data,
		ph_write
	} phase_t;

	phase_t                  phase;
	logic [cnt_bits-1:0]     idx;
	logic [ram_adr_bits-1:0] src_base;
	logic [ram_adr_bits-1:0] src_adr;
	sm83_pkg::word_t         data_q;

	assign src_adr = src_base + ram_adr_bits'(idx); // Wraps at the RAM size.

	always_comb begin
		req       = '0;
		req.wdata = data_q;
		req.adr   = sm83_pkg::adr_t'(src_adr);
		if (phase == ph_write)
			req.adr = sm83_pkg::dma_dst_base + sm83_pkg::adr_t'(idx);
		req.rd = busy && (phase == ph_read);
		req.wr = busy && (phase == ph_write);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy  <= 1'b0;
			phase <= ph_read;
			idx   <= '0;
		end else if (start) begin
			busy  <= 1'b1;
			phase <= ph_read;
			idx   <= '0;
		end else if (busy) begin
			case (phase)
				ph_read: if (grant)
					phase <= ph_data;
				ph_data: phase <= ph_write;
				default: if (grant) begin
					phase <= ph_read;
					if (idx == cnt_bits'(dma_len - 1))
						busy <= 1'b0; // Last byte written.
					else
						idx <= idx + 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			src_base <= ram_adr_bits'(int'(start_val) * dma_len);
		if (phase == ph_data)
			data_q <= rdata;
	end

endmodule

/* verilog/bus_arbiter.sv */
module bus_arbiter #(
	parameter int ram_adr_bits = 10
) (
	input  logic                    clk,
	input  logic                    reset,
	input  sm83_pkg::bus_req_t      host_req,
	input  sm83_pkg::bus_req_t      dma_req,
	input  sm83_pkg::bus_req_t      cpu_req,
	input  logic                    dma_busy,
	output logic                    cpu_grant,
	output logic                    dma_grant,
	output logic                    ram_we,
	output logic [ram_adr_bits-1:0] ram_adr,
	output sm83_pkg::word_t         ram_wdata,
	output logic                    dma_start,
	output sm83_pkg::word_t         dma_start_val
);

	logic               host_act;
	logic               dma_act;
	logic               cpu_act;
	logic               granted;
	logic               dma_trigger;
	sm83_pkg::bus_req_t sel;

	assign host_act = host_req.rd | host_req.wr;
	assign dma_act  = dma_req.rd | dma_req.wr;
	assign cpu_act  = cpu_req.rd | cpu_req.wr;

	// Host, then DMA, then core. Core waits out a whole copy.
	assign dma_grant = dma_act && !host_act;
	assign cpu_grant = cpu_act && !host_act && !dma_act && !dma_busy && !dma_start;
	assign granted   = host_act | dma_grant | cpu_grant;

	always_comb begin
		if (host_act)
			sel = host_req;
		else if (dma_act)
			sel = dma_req;
		else
			sel = cpu_req;
	end

	assign dma_trigger = cpu_grant && cpu_req.wr && (cpu_req.adr == sm83_pkg::dma_reg_adr);

	assign ram_we    = granted && sel.wr && !dma_trigger; // Trigger store stays off RAM.
	assign ram_adr   = sel.adr[ram_adr_bits-1:0];
	assign ram_wdata = sel.wdata;

	always_ff @(posedge clk) begin
		if (reset)
			dma_start <= 1'b0;
		else
			dma_start <= dma_trigger;
	end

	always_ff @(posedge clk) begin
		if (dma_trigger)
			dma_start_val <= cpu_req.wdata;
	end

endmodule

/* verilog/sys_ram.sv */
module sys_ram #(
	parameter int ram_adr_bits = 10
) (
	input  logic                    clk,
	input  logic                    we,
	input  logic [ram_adr_bits-1:0] adr,
	input  sm83_pkg::word_t         wdata,
	output sm83_pkg::word_t         rdata
);

	localparam int depth = 2 ** ram_adr_bits;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Storage.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	sm83_pkg::word_t mem [depth];

	always_ff @(posedge clk) begin
		if (we)
			mem[adr] <= wdata;
	end

	// Old contents on a write cycle.
	always_ff @(posedge clk) begin
		rdata <= mem[adr];
	end

endmodule

/* verilog/sm83_system.sv */
module sm83_system #(
	parameter int ram_adr_bits = 10,
	parameter int dma_len      = 16
) (
	input  logic               clk,
	input  logic               reset,
	input  sm83_pkg::bus_req_t host_req,
	output sm83_pkg::word_t    host_rdata,
	output logic               halted
);

	sm83_pkg::bus_req_t      cpu_req;
	sm83_pkg::bus_req_t      dma_req;
	logic                    cpu_grant;
	logic                    dma_grant;
	logic                    dma_busy;
	logic                    dma_start;
	sm83_pkg::word_t         dma_start_val;
	logic                    ram_we;
	logic [ram_adr_bits-1:0] ram_adr;
	sm83_pkg::word_t         ram_wdata;
	sm83_pkg::word_t         ram_rdata;

	assign host_rdata = ram_rdata; // Read data fans out to every peer.

	sm83_core u_core (
		.clk    (clk),
		.reset  (reset),
		.ncyc   (cpu_grant),
		.req    (cpu_req),
		.din    (ram_rdata),
		.halted (halted)
	);

	dma_engine #(
		.ram_adr_bits (ram_adr_bits),
		.dma_len      (dma_len)
	) u_dma (
		.clk       (clk),
		.reset     (reset),
		.start     (dma_start),
		.start_val (dma_start_val),
		.grant     (dma_grant),
		.rdata     (ram_rdata),
		.req       (dma_req),
		.busy      (dma_busy)
	);

	bus_arbiter #(
		.ram_adr_bits (ram_adr_bits)
	) u_arb (
		.clk           (clk),
		.reset         (reset),
		.host_req      (host_req),
		.dma_req       (dma_req),
		.cpu_req       (cpu_req),
		.dma_busy      (dma_busy),
		.cpu_grant     (cpu_grant),
		.dma_grant     (dma_grant),
		.ram_we        (ram_we),
		.ram_adr       (ram_adr),
		.ram_wdata     (ram_wdata),
		.dma_start     (dma_start),
		.dma_start_val (dma_start_val)
	);

	sys_ram #(
		.ram_adr_bits (ram_adr_bits)
	) u_ram (
		.clk   (clk),
		.we    (ram_we),
		.adr   (ram_adr),
		.wdata (ram_wdata),
		.rdata (ram_rdata)
	);

endmodule

/* test/sm83_bus_properties.sv */
module sm83_bus_properties (
	input logic               clk,
	input logic               reset,
	input sm83_pkg::bus_req_t host_req,
	input sm83_pkg::bus_req_t dma_req,
	input sm83_pkg::bus_req_t cpu_req,
	input logic               dma_busy,
	input logic               cpu_grant,
	input logic               dma_grant
);
	timeunit 1ns;
	timeprecision 100ps;

	logic host_act;
	logic cpu_wait;
	logic dma_wait;
	int   fails = 0; // Failed assertion count.

	assign host_act = host_req.rd | host_req.wr; // Host is granted whenever it asks.
	assign cpu_wait = (cpu_req.rd | cpu_req.wr) && !cpu_grant;
	assign dma_wait = (dma_req.rd | dma_req.wr) && !dma_grant;

	one_grant: assert property (@(posedge clk) disable iff (reset)
		$onehot0({host_act, dma_grant, cpu_grant}))
		else begin
			fails++;
			$error("More than one grant in one cycle.");
		end

	no_cpu_in_copy: assert property (@(posedge clk) disable iff (reset)
		dma_busy |-> !cpu_grant)
		else begin
			fails++;
			$error("Core granted while the DMA copy runs.");
		end

	cpu_holds: assert property (@(posedge clk) disable iff (reset)
		cpu_wait |=> $stable(cpu_req))
		else begin
			fails++;
			$error("Core request changed before its grant.");
		end

	dma_holds: assert property (@(posedge clk) disable iff (reset)
		dma_wait |=> $stable(dma_req))
		else begin
			fails++;
			$error("DMA request changed before its grant.");
		end

endmodule

/* test/sm83_checker.sv */
module sm83_checker #(
	parameter int ram_adr_bits = 10,
	parameter int dma_len      = 16
) (
	input  logic               clk,
	input  logic               reset,
	input  sm83_pkg::bus_req_t host_req,
	input  sm83_pkg::word_t    host_rdata,
	input  logic               halted,
	input  logic               ram_we,
	input  sm83_pkg::flags_t   flags,
	output int                 mismatches,
	output int                 late_writes,
	output int                 model_errors
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int depth = 2 ** ram_adr_bits;

	sm83_pkg::word_t  model [depth]; // Image loaded by the host, then run.
	sm83_pkg::adr_t   pc;
	sm83_pkg::adr_t   rd_adr;
	sm83_pkg::flags_t exp_flags;
	logic             rd_pend    = 1'b0;
	logic             was_reset  = 1'b0;
	logic             was_halted = 1'b0;

	initial begin
		mismatches   = 0;
		late_writes  = 0;
		model_errors = 0;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference interpreter.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic sm83_pkg::word_t next_byte();
		next_byte = model[pc[ram_adr_bits-1:0]];
		pc        = pc + 16'd1;
	endfunction

	task automatic store(input sm83_pkg::adr_t adr, input sm83_pkg::word_t val);
		int src;
		if (adr == sm83_pkg::dma_reg_adr) begin
			// Whole block lands at once.
			src = (int'(val) * dma_len) % depth;
			for (int i = 0; i < dma_len; i++)
				model[ram_adr_bits'(int'(sm83_pkg::dma_dst_base) + i)] =
					model[ram_adr_bits'(src + i)];
		end else
			model[adr[ram_adr_bits-1:0]] = val;
	endtask

	task automatic run_model();
		sm83_pkg::adr_t  hl;
		sm83_pkg::word_t a;
		sm83_pkg::word_t b;
		sm83_pkg::word_t op;
		sm83_pkg::word_t lo;
		sm83_pkg::word_t hi;
		pc        = '0;
		hl        = '0;
		a         = '0;
		exp_flags = '0;
		for (int step = 0; step < 10000; step++) begin
			op = next_byte();
			if (op == sm83_pkg::op_halt)
				return;
			case (op)
				sm83_pkg::op_ld_a_n:  a = next_byte();
				sm83_pkg::op_add_n: begin
					b           = next_byte();
					exp_flags.h = (int'(a[3:0]) + int'(b[3:0])) > 15;
					exp_flags.c = (int'(a) + int'(b)) > 255;
					exp_flags.n = 1'b0;
					a           = a + b; // Wraps at 8 bits.
					exp_flags.z = (a == 8'h00);
				end
				sm83_pkg::op_sub_n: begin
					b           = next_byte();
					exp_flags.h = a[3:0] < b[3:0]; // Borrow out of the low nibble.
					exp_flags.c = a < b;
					exp_flags.n = 1'b1;
					a           = a - b;
					exp_flags.z = (a == 8'h00);
				end
				sm83_pkg::op_and_n: begin
					a           = a & next_byte();
					exp_flags.z = (a == 8'h00);
					exp_flags.n = 1'b0;
					exp_flags.h = 1'b1;
					exp_flags.c = 1'b0;
				end
				sm83_pkg::op_ld_a_hl: a = model[hl[ram_adr_bits-1:0]];
				sm83_pkg::op_ld_hl_a: store(hl, a);
				sm83_pkg::op_inc_hl:  hl = hl + 16'd1;
				sm83_pkg::op_jp: begin
					lo = next_byte();
					hi = next_byte();
					pc = {hi, lo};
				end
				default: if ((op & 8'hCF) == sm83_pkg::op_ld_rr_base) begin
					lo = next_byte();
					hi = next_byte();
					if (op[5:4] == 2'd2)
						hl = {hi, lo}; // Only HL matters to memory.
				end
			endcase
		end
		model_errors++;
		$display("Error at %0t: reference model found no HALT in its step limit", $time);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus watching.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(posedge clk) begin
		if (rd_pend && host_rdata !== model[rd_adr[ram_adr_bits-1:0]]) begin
			mismatches++;
			$display("[FAIL] %0t: adr %03h expected %02h read %02h", $time, rd_adr,
				model[rd_adr[ram_adr_bits-1:0]], host_rdata);
		end
		rd_pend = halted && !reset && host_req.rd; // Data shows up next edge.
		rd_adr  = host_req.adr;
		if (reset && host_req.wr)
			model[host_req.adr[ram_adr_bits-1:0]] = host_req.wdata;
		if (was_reset && !reset)
			run_model();
		was_reset = reset;
		if (halted && !was_halted && flags !== exp_flags) begin
			mismatches++;
			$display("[FAIL] %0t: flags znhc expected %04b read %04b", $time,
				exp_flags, flags);
		end
		was_halted = halted;
		if (halted && ram_we && !host_req.wr) begin
			late_writes++;
			$display("Error at %0t: RAM written after the core halted", $time);
		end
	end

endmodule

/* test/tb_sm83_system.sv */
module tb_sm83_system;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ram_adr_bits = 10;
	localparam int dma_len      = 16;
	localparam int depth        = 2 ** ram_adr_bits;
	localparam int n_progs      = 6;

	logic               clk;
	logic               reset;
	sm83_pkg::bus_req_t host_req;
	sm83_pkg::word_t    host_rdata;
	logic               halted;
	int                 mismatches;
	int                 late_writes;
	int                 model_errors;
	integer             seed = 32'h5695770d;
	sm83_pkg::word_t    prog [$];

	sm83_system #(
		.ram_adr_bits (ram_adr_bits),
		.dma_len      (dma_len)
	) u_dut (
		.clk        (clk),
		.reset      (reset),
		.host_req   (host_req),
		.host_rdata (host_rdata),
		.halted     (halted)
	);

	sm83_checker #(
		.ram_adr_bits (ram_adr_bits),
		.dma_len      (dma_len)
	) u_checker (
		.clk          (clk),
		.reset        (reset),
		.host_req     (host_req),
		.host_rdata   (host_rdata),
		.halted       (halted),
		.ram_we       (u_dut.ram_we),
		.flags        (u_dut.u_core.f),
		.mismatches   (mismatches),
		.late_writes  (late_writes),
		.model_errors (model_errors)
	);

	bind bus_arbiter sm83_bus_properties u_props (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		repeat (n_progs * 4000) @(posedge clk);
		$display("Timeout: the core never halted within %0d cycles", n_progs * 4000);
		$display("FAIL: see errors above");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Program generation.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic int rand_below(input int range);
		return int'($unsigned($random(seed)) % range);
	endfunction

	function automatic logic is_decoded(input sm83_pkg::word_t op);
		return op inside {8'h01, 8'h11, 8'h21, 8'h31, 8'h3E, 8'h77, 8'h7E,
		                  8'h23, 8'hC6, 8'hD6, 8'hE6, 8'hC3, 8'h76};
	endfunction

	task automatic emit(input int b);
		prog.push_back(8'(b));
	endtask

	task automatic emit_ld_hl(input int adr);
		emit(8'h21);
		emit(adr);
		emit(adr >> 8);
	endtask

	task automatic build_program();
		int              hl;
		int              k;
		int              target;
		sm83_pkg::word_t op;
		prog.delete();
		hl = 16'h0100 + rand_below(16'h0200); // Stores stay in 0x100 to 0x2FF.
		emit_ld_hl(hl);
		while (prog.size() < 160) begin
			case (rand_below(10))
				0: begin
					emit(8'h3E);
					emit(rand_below(256));
				end
				1: begin
					emit(8'hC6 + 16 * rand_below(3)); // ADD, SUB or AND.
					emit(rand_below(256));
				end
				2: emit(8'h77);
				3: begin
					emit(8'h77);
					emit(8'h7E); // Reads the byte just stored.
				end
				4: emit(8'h7E);
				5: if (hl < 16'h02FF) begin
					emit(8'h23);
					hl++;
				end
				6: begin
					k      = rand_below(4);
					target = prog.size() + 3 + k;
					emit(8'hC3);
					emit(target);
					emit(target >> 8);
					repeat (k) emit(rand_below(256)); // Junk bytes the jump skips.
				end
				7: begin
					k = rand_below(3);
					emit(8'h01 + 16 * ((k == 2) ? 3 : k)); // BC, DE or SP.
					emit(rand_below(256));
					emit(rand_below(256));
				end
				8: begin
					do op = 8'(rand_below(256)); while (is_decoded(op));
					emit(op);
				end
				default: begin
					emit_ld_hl(16'h03FF);
					emit(8'h3E);
					emit(rand_below(256));
					emit(8'h77); // Starts a copy.
					hl = 16'h0100 + rand_below(16'h0200);
					emit_ld_hl(hl);
				end
			endcase
		end
		emit(8'h76);
	endtask

	task automatic host_access(input logic wr, input int adr, input int val);
		@(negedge clk);
		host_req.rd    = !wr;
		host_req.wr    = wr;
		host_req.adr   = 16'(adr);
		host_req.wdata = 8'(val);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		reset    = 1'b1;
		host_req = '0;
		for (int p = 0; p < n_progs; p++) begin
			@(negedge clk);
			reset    = 1'b1;
			host_req = '0;
			repeat (16) @(negedge clk);
			build_program();
			for (int i = 0; i < depth; i++)
				host_access(1'b1, i, 0);
			foreach (prog[i])
				host_access(1'b1, i, prog[i]);
			@(negedge clk);
			host_req = '0;
			reset    = 1'b0;
			while (!halted)
				@(negedge clk);
			for (int i = 0; i < depth; i++)
				host_access(1'b0, i, 0);
			@(negedge clk);
			host_req = '0;
			@(negedge clk); // Last read is compared here.
		end
		$display("Errors: %0d mismatches, %0d late writes, %0d model errors, %0d assertions",
			mismatches, late_writes, model_errors, u_dut.u_arb.u_props.fails);
		if (mismatches == 0 && late_writes == 0 && model_errors == 0 &&
		    u_dut.u_arb.u_props.fails == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* verilog.f */
verilog/sm83_pkg.sv
verilog/sm83_alu.sv
verilog/sm83_core.sv
verilog/dma_engine.sv
verilog/bus_arbiter.sv
verilog/sys_ram.sv
verilog/sm83_system.sv
test/sm83_bus_properties.sv
test/sm83_checker.sv
test/tb_sm83_system.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_sm83_system
FLAGS     ?= --binary --timing --assert --timescale 1ns/100ps -j 0 -Wno-fatal
OBJ_DIR   ?= obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build lint clean

all: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f verilog.f

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/100ps -Wall --top-module $(TOP) \
		-f verilog.f

clean:
	rm -rf $(OBJ_DIR)
